//--- design/drain_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

// drains two queues onto one output bus, one word per cycle at most
// almost full queue first, otherwise round robin
module drain_arbiter (
	input wire clk,
	input wire rst,
	input wire clr,
	input wire drain_en,
	drain_if.arb cmd_q,
	drain_if.arb data_q,
	output logic out_valid,
	output xfer_pkg::src_t out_src,
	output xfer_pkg::data_t out_word
);

	// round robin pointer, names the queue favored next
	xfer_pkg::src_t rr_ptr;
	// grant decided by the pointer, so the pointer moves
	logic rr_move;

	logic cmd_urg;
	logic data_urg;
	logic pop_cmd;
	logic pop_data;

	// grant delayed one cycle to line up with the RAM read
	logic sel_vld;
	xfer_pkg::src_t sel_src;

	xfer_pkg::cmd_t cmd_word;
	xfer_pkg::beat_t beat;

	assign cmd_urg = cmd_q.req & cmd_q.urgent;
	assign data_urg = data_q.req & data_q.urgent;
	assign cmd_word = cmd_q.word;

	////////////////////
	// selection
	////////////////////

	always_comb begin
		pop_cmd = 1'b0;
		pop_data = 1'b0;
		rr_move = 1'b0;
		if (drain_en) begin
			if (cmd_urg != data_urg) begin
				// exactly one urgent queue wins outright
				pop_cmd = cmd_urg;
				pop_data = data_urg;
			end else if (cmd_q.req && data_q.req) begin
				// both urgent or both plain, pointer decides
				rr_move = 1'b1;
				pop_cmd = (rr_ptr == xfer_pkg::SRC_CMD);
				pop_data = (rr_ptr == xfer_pkg::SRC_DATA);
			end else begin
				// at most one requester
				rr_move = cmd_q.req | data_q.req;
				pop_cmd = cmd_q.req;
				pop_data = data_q.req;
			end
		end
	end

	assign cmd_q.pop = pop_cmd;
	assign data_q.pop = pop_data;

	// pointer flips away from the queue just served
	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			rr_ptr <= xfer_pkg::SRC_CMD;
		end else if (rr_move) begin
			rr_ptr <= pop_cmd ? xfer_pkg::SRC_DATA : xfer_pkg::SRC_CMD;
		end
	end

	////////////////////
	// output beat
	////////////////////

	// valid strobes, two stages
	// items already popped still come out after clr
	always_ff @(posedge clk) begin
		if (!rst) begin
			sel_vld <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			sel_vld <= pop_cmd | pop_data;
			out_valid <= sel_vld;
		end
	end

	// word is on the drain interface one cycle after the pop
	always_ff @(posedge clk) begin
		sel_src <= pop_data ? xfer_pkg::SRC_DATA : xfer_pkg::SRC_CMD;
		if (sel_vld) begin
			beat.src <= sel_src;
			// command words zero extended to the bus width
			beat.word <= (sel_src == xfer_pkg::SRC_CMD) ?
				xfer_pkg::data_t'(cmd_word) : data_q.word;
		end
	end

	assign out_src = beat.src;
	assign out_word = beat.word;

endmodule

`default_nettype wire

//--- design/drain_if.sv
`timescale 1ns/100ps
`default_nettype none

// link between one queue and the drain arbiter
// pop in cycle t removes the head, the word shows up in t+1
// and holds until the next pop
interface drain_if #(
	parameter type T = logic
);

	// queue holds at least one word
	logic req;
	// queue is almost full, serve it first
	logic urgent;
	// arbiter takes the head this cycle, only while req is high
	logic pop;
	// head word, registered read data of the RAM
	T word;

	modport fifo (
		output req,
		output urgent,
		output word,
		input pop
	);

	modport arb (
		input req,
		input urgent,
		input word,
		output pop
	);

endinterface

`default_nettype wire

//--- design/dual_port_ram.sv
`timescale 1ns/100ps
`default_nettype none

// simple dual port storage
// one write port, one read port with registered output
module dual_port_ram #(
	parameter int width = 8,
	parameter int addr_width = 4
) (
	input wire clk,
	input wire [addr_width-1:0] waddr,
	input wire [width-1:0] wdata,
	input wire we,
	input wire [addr_width-1:0] raddr,
	input wire re,
	output logic [width-1:0] rdata
);

	// full 2^addr_width entries
	logic [width-1:0] mem [0:(1<<addr_width)-1];

	// write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// read port, output holds between reads
	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= mem[raddr];
		end
	end

endmodule

`default_nettype wire

//--- design/fifo_consts.svh
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

////////////////////
// queue geometry
////////////////////

// address width of one queue
`define FIFO_AW 4

// entries per queue, 2^FIFO_AW
`define FIFO_DEPTH 16

// almost threshold
// almost_empty while count < FIFO_THRESH
// almost_full while count >= FIFO_DEPTH - FIFO_THRESH + 1
`define FIFO_THRESH 4

`endif

//--- design/fifo_pkg.sv
`default_nettype none

`include "fifo_consts.svh"

package fifo_pkg;

	// occupancy count, one bit wider than the address so 16 fits
	typedef logic [`FIFO_AW:0] count_t;

	// quarter-fill level
	// 0: below 1/4, 1: below 1/2, 2: below 3/4, 3: 3/4 or more
	typedef logic [1:0] level_t;

	// registered queue status, all fields updated at the same edge
	typedef struct packed {
		logic full;
		logic empty;
		logic almost_full;
		logic almost_empty;
		level_t level;
	} status_t;

endpackage

`default_nettype wire

//--- design/ingress_buffer.sv
`timescale 1ns/100ps
`default_nettype none

// two queue ingress buffer
// command and data producers each fill their own FIFO
// one arbiter drains both onto the output bus
module ingress_buffer (
	input wire clk,
	input wire rst,
	input wire clr,
	input wire cmd_we,
	input wire xfer_pkg::cmd_t cmd_din,
	input wire data_we,
	input wire xfer_pkg::data_t data_din,
	input wire drain_en,
	// command queue flags
	output logic cmd_full,
	output logic cmd_empty,
	output logic cmd_almost_full,
	output logic cmd_almost_empty,
	output fifo_pkg::level_t cmd_level,
	// data queue flags
	output logic data_full,
	output logic data_empty,
	output logic data_almost_full,
	output logic data_almost_empty,
	output fifo_pkg::level_t data_level,
	// output beat
	output logic out_valid,
	output xfer_pkg::src_t out_src,
	output xfer_pkg::data_t out_word
);

	fifo_pkg::status_t cmd_status;
	fifo_pkg::status_t data_status;

	drain_if #(.T(xfer_pkg::cmd_t)) cmd_q ();
	drain_if #(.T(xfer_pkg::data_t)) data_q ();

	////////////////////
	// queues
	////////////////////

	sync_fifo #(.T(xfer_pkg::cmd_t)) u_cmd_fifo (
		.clk(clk),
		.rst(rst),
		.clr(clr),
		.we(cmd_we),
		.din(cmd_din),
		.status(cmd_status),
		.drain(cmd_q.fifo)
	);

	sync_fifo #(.T(xfer_pkg::data_t)) u_data_fifo (
		.clk(clk),
		.rst(rst),
		.clr(clr),
		.we(data_we),
		.din(data_din),
		.status(data_status),
		.drain(data_q.fifo)
	);

	////////////////////
	// drain
	////////////////////

	drain_arbiter u_arb (
		.clk(clk),
		.rst(rst),
		.clr(clr),
		.drain_en(drain_en),
		.cmd_q(cmd_q.arb),
		.data_q(data_q.arb),
		.out_valid(out_valid),
		.out_src(out_src),
		.out_word(out_word)
	);

	// flatten status structs onto plain ports
	assign cmd_full = cmd_status.full;
	assign cmd_empty = cmd_status.empty;
	assign cmd_almost_full = cmd_status.almost_full;
	assign cmd_almost_empty = cmd_status.almost_empty;
	assign cmd_level = cmd_status.level;
	assign data_full = data_status.full;
	assign data_empty = data_status.empty;
	assign data_almost_full = data_status.almost_full;
	assign data_almost_empty = data_status.almost_empty;
	assign data_level = data_status.level;

endmodule

`default_nettype wire

//--- design/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "fifo_consts.svh"

// synchronous FIFO with guard bit, occupancy count and registered flags
// writes come from a producer strobe and reads from the drain interface
module sync_fifo #(
	parameter type T = logic
) (
	input wire clk,
	input wire rst,
	input wire clr,
	input wire we,
	input wire T din,
	output fifo_pkg::status_t status,
	drain_if.fifo drain
);

	////////////////////
	// thresholds
	////////////////////

	localparam fifo_pkg::count_t ae_limit = fifo_pkg::count_t'(`FIFO_THRESH);
	localparam fifo_pkg::count_t af_limit =
		fifo_pkg::count_t'(`FIFO_DEPTH - `FIFO_THRESH + 1);

	////////////////////
	// state
	////////////////////

	// write and read pointers
	logic [`FIFO_AW-1:0] wp;
	logic [`FIFO_AW-1:0] rp;
	logic [`FIFO_AW-1:0] wp_nxt;
	logic [`FIFO_AW-1:0] rp_nxt;

	// guard bit set when a write makes the pointers meet
	logic gb;
	logic gb_nxt;

	// occupancy
	fifo_pkg::count_t cnt;
	fifo_pkg::count_t cnt_nxt;

	// accepted write and read this cycle
	logic wr;
	logic rd;

	// a write into a full queue is dropped
	assign wr = we & ~status.full;
	// arbiter pops only while req is high
	assign rd = drain.pop;

	////////////////////
	// storage
	////////////////////

	// read data goes straight onto the drain word
	dual_port_ram #(
		.width($bits(T)),
		.addr_width(`FIFO_AW)
	) u_ram (
		.clk(clk),
		.waddr(wp),
		.wdata(din),
		.we(wr),
		.raddr(rp),
		.re(rd),
		.rdata(drain.word)
	);

	////////////////////
	// next state
	////////////////////

	always_comb begin
		wp_nxt = wr ? wp + 1'b1 : wp;
		rp_nxt = rd ? rp + 1'b1 : rp;

		// a lone write that makes the pointers meet fills the queue
		// any lone read leaves room again
		gb_nxt = gb;
		if (wr && !rd && ((wp + 1'b1) == rp)) begin
			gb_nxt = 1'b1;
		end else if (rd && !wr) begin
			gb_nxt = 1'b0;
		end

		// up/down count holds on simultaneous write and read
		cnt_nxt = cnt;
		if (wr && !rd) begin
			cnt_nxt = cnt + 1'b1;
		end else if (rd && !wr) begin
			cnt_nxt = cnt - 1'b1;
		end
	end

	////////////////////
	// registers and flags
	////////////////////

	// all flags come from next state so a write at edge t
	// is reflected in every flag in cycle t+1
	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			wp <= '0;
			rp <= '0;
			gb <= 1'b0;
			cnt <= '0;
			status.full <= 1'b0;
			status.empty <= 1'b1;
			status.almost_full <= 1'b0;
			status.almost_empty <= 1'b1;
			status.level <= '0;
		end else begin
			wp <= wp_nxt;
			rp <= rp_nxt;
			gb <= gb_nxt;
			cnt <= cnt_nxt;
			status.full <= (wp_nxt == rp_nxt) && gb_nxt;
			status.empty <= (wp_nxt == rp_nxt) && !gb_nxt;
			status.almost_full <= cnt_nxt >= af_limit;
			status.almost_empty <= cnt_nxt < ae_limit;
			// top two bits below msb forced to 3 when completely full
			status.level <= {2{cnt_nxt[`FIFO_AW]}} | cnt_nxt[`FIFO_AW-1:`FIFO_AW-2];
		end
	end

	// request and urgency toward the arbiter
	assign drain.req = ~status.empty;
	assign drain.urgent = status.almost_full;

endmodule

`default_nettype wire

//--- design/xfer_pkg.sv
`default_nettype none

package xfer_pkg;

	// command producer word
	typedef logic [59:0] cmd_t;

	// data producer word, also the width of the output bus
	typedef logic [127:0] data_t;

	// which queue a beat came from
	typedef enum logic {
		SRC_CMD = 1'b0,
		SRC_DATA = 1'b1
	} src_t;

	// one beat on the shared output bus
	// command words sit in the low bits, upper bits zero
	typedef struct packed {
		src_t src;
		data_t word;
	} beat_t;

endpackage

`default_nettype wire

//--- dv/tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

// free running clock and power-on reset for the testbench
module tb_clkgen #(
	parameter int period = 40,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// active low, released just after the last reset edge
	initial begin
		rst = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#2;
		rst = 1'b1;
	end

endmodule

`default_nettype wire

//--- dv/tb_ingress_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "fifo_consts.svh"

module tb_ingress_buffer;

	localparam int depth = `FIFO_DEPTH;
	localparam int af_count = `FIFO_DEPTH - `FIFO_THRESH + 1;
	localparam int beat_timeout = 100;
	// cycle budget per test in order reset, order, flags, rr, urgency and clear
	localparam int run_cycles = 10 + 40 + 80 + 40 + 60 + 30;
	localparam int watchdog_ns = run_cycles * 3 * 40;

	logic clk;
	logic rst;
	logic clr;
	logic cmd_we;
	xfer_pkg::cmd_t cmd_din;
	logic data_we;
	xfer_pkg::data_t data_din;
	logic drain_en;
	logic cmd_full;
	logic cmd_empty;
	logic cmd_almost_full;
	logic cmd_almost_empty;
	fifo_pkg::level_t cmd_level;
	logic data_full;
	logic data_empty;
	logic data_almost_full;
	logic data_almost_empty;
	fifo_pkg::level_t data_level;
	logic out_valid;
	xfer_pkg::src_t out_src;
	xfer_pkg::data_t out_word;

	integer seed = 32'h1287_ce46;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// reference queues and round robin pointer where 1 favors data
	logic [59:0] cmd_model[$];
	logic [127:0] data_model[$];
	logic rr_data = 1'b0;
	// beats as {src, word}
	logic [128:0] expected[$];
	logic [128:0] seen[$];

	tb_clkgen #(.period(40), .reset_cycles(4)) u_clkgen (
		.clk(clk),
		.rst(rst)
	);

	ingress_buffer uut (
		.clk(clk),
		.rst(rst),
		.clr(clr),
		.cmd_we(cmd_we),
		.cmd_din(cmd_din),
		.data_we(data_we),
		.data_din(data_din),
		.drain_en(drain_en),
		.cmd_full(cmd_full),
		.cmd_empty(cmd_empty),
		.cmd_almost_full(cmd_almost_full),
		.cmd_almost_empty(cmd_almost_empty),
		.cmd_level(cmd_level),
		.data_full(data_full),
		.data_empty(data_empty),
		.data_almost_full(data_almost_full),
		.data_almost_empty(data_almost_empty),
		.data_level(data_level),
		.out_valid(out_valid),
		.out_src(out_src),
		.out_word(out_word)
	);

	// beats are collected mid-cycle where the registered outputs are stable
	always @(negedge clk) begin
		if (out_valid === 1'b1) begin
			seen.push_back({out_src, out_word});
		end
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired, the run took longer than all tests together");
		$display("Done: errors found");
		$finish;
	end

	////////////////////
	// helpers
	////////////////////

	// advance to 2 ns after the next rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic report_error(input string test, input logic [128:0] exp,
		input logic [128:0] act);
		$display("ERROR %s: expected %0h, actual %0h", test, exp, act);
		errors++;
	endtask

	task automatic finish_test(input string test, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("%s: passed", test);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", test, errors - errors_before);
		end
	endtask

	function automatic logic [127:0] random_data();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	function automatic logic [59:0] random_cmd();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[59:0];
	endfunction

	// one strobe per call and the model drops a word when its queue is full
	task automatic push_cmd(input logic [59:0] w);
		cmd_we = 1'b1;
		cmd_din = w;
		if (cmd_model.size() < depth) cmd_model.push_back(w);
		step();
		cmd_we = 1'b0;
	endtask

	task automatic push_data(input logic [127:0] w);
		data_we = 1'b1;
		data_din = w;
		if (data_model.size() < depth) data_model.push_back(w);
		step();
		data_we = 1'b0;
	endtask

	// flags for an occupancy of n with the quarter level capped at 3
	task automatic check_flags(input string test, input logic data_side, input int n);
		logic [5:0] exp;
		logic [5:0] act;
		exp[5] = (n == depth);
		exp[4] = (n == 0);
		exp[3] = (n >= af_count);
		exp[2] = (n < `FIFO_THRESH);
		exp[1:0] = (n >= depth) ? 2'd3 : 2'(n / (depth / 4));
		if (data_side) begin
			act = {data_full, data_empty, data_almost_full, data_almost_empty, data_level};
		end else begin
			act = {cmd_full, cmd_empty, cmd_almost_full, cmd_almost_empty, cmd_level};
		end
		if (act !== exp) report_error(test, exp, act);
	endtask

	// empties the model queues by the arbiter rule
	// a lone urgent queue wins and leaves the pointer alone
	task automatic predict_drain();
		logic cmd_urg;
		logic data_urg;
		logic pick_data;
		while (cmd_model.size() > 0 || data_model.size() > 0) begin
			cmd_urg = cmd_model.size() >= af_count;
			data_urg = data_model.size() >= af_count;
			if (cmd_urg != data_urg) begin
				pick_data = data_urg;
			end else begin
				if (cmd_model.size() > 0 && data_model.size() > 0) pick_data = rr_data;
				else pick_data = data_model.size() > 0;
				rr_data = !pick_data;
			end
			if (pick_data) begin
				expected.push_back({xfer_pkg::SRC_DATA, data_model.pop_front()});
			end else begin
				expected.push_back({xfer_pkg::SRC_CMD, 68'd0, cmd_model.pop_front()});
			end
		end
	endtask

	// beats matched by order and then both lists are emptied
	task automatic check_beats(input string test);
		int waited;
		waited = 0;
		while (seen.size() < expected.size() && waited < beat_timeout) begin
			step();
			waited++;
		end
		if (seen.size() < expected.size()) begin
			$display("%s: timed out waiting for output beats", test);
			errors++;
		end
		// room for any stray beat still in the pipeline
		repeat (4) step();
		if (seen.size() != expected.size()) report_error(test, expected.size(), seen.size());
		for (int i = 0; i < seen.size() && i < expected.size(); i++) begin
			if (seen[i] !== expected[i]) report_error(test, expected[i], seen[i]);
		end
		seen.delete();
		expected.delete();
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_reset_state();
		int e0;
		e0 = errors;
		if (out_valid !== 1'b0) report_error("reset_state", 1'b0, out_valid);
		check_flags("reset_state", 1'b0, 0);
		check_flags("reset_state", 1'b1, 0);
		finish_test("reset_state", e0);
	endtask

	task automatic test_order();
		int e0;
		e0 = errors;
		drain_en = 1'b1;
		for (int i = 0; i < 5; i++) push_cmd(random_cmd());
		predict_drain();
		check_beats("order");
		drain_en = 1'b0;
		finish_test("order", e0);
	endtask

	task automatic test_flags();
		int e0;
		e0 = errors;
		// seventeenth write lands on a full queue
		for (int i = 0; i < depth + 1; i++) begin
			push_data(random_data());
			check_flags("flags", 1'b1, data_model.size());
		end
		drain_en = 1'b1;
		predict_drain();
		check_beats("flags");
		drain_en = 1'b0;
		check_flags("flags", 1'b1, 0);
		finish_test("flags", e0);
	endtask

	task automatic test_round_robin();
		int e0;
		e0 = errors;
		for (int i = 0; i < 3; i++) begin
			push_cmd(random_cmd());
			push_data(random_data());
		end
		drain_en = 1'b1;
		predict_drain();
		check_beats("round_robin");
		drain_en = 1'b0;
		finish_test("round_robin", e0);
	endtask

	task automatic test_urgency();
		int e0;
		e0 = errors;
		for (int i = 0; i < 14; i++) push_data(random_data());
		for (int i = 0; i < 3; i++) push_cmd(random_cmd());
		check_flags("urgency", 1'b1, 14);
		drain_en = 1'b1;
		predict_drain();
		check_beats("urgency");
		drain_en = 1'b0;
		finish_test("urgency", e0);
	endtask

	task automatic test_clear();
		int e0;
		e0 = errors;
		for (int i = 0; i < 4; i++) push_cmd(random_cmd());
		for (int i = 0; i < 5; i++) push_data(random_data());
		clr = 1'b1;
		step();
		clr = 1'b0;
		cmd_model.delete();
		data_model.delete();
		rr_data = 1'b0;
		check_flags("clear", 1'b0, 0);
		check_flags("clear", 1'b1, 0);
		drain_en = 1'b1;
		repeat (8) step();
		if (seen.size() != 0) begin
			$display("clear: a beat came out of a cleared queue");
			errors++;
		end
		drain_en = 1'b0;
		seen.delete();
		finish_test("clear", e0);
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		clr = 1'b0;
		cmd_we = 1'b0;
		cmd_din = '0;
		data_we = 1'b0;
		data_din = '0;
		drain_en = 1'b0;
		wait (rst === 1'b1);
		step();
		test_reset_state();
		test_order();
		test_flags();
		test_round_robin();
		test_urgency();
		test_clear();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/fifo_pkg.sv
design/xfer_pkg.sv
design/drain_if.sv
design/dual_port_ram.sv
design/sync_fifo.sv
design/drain_arbiter.sv
design/ingress_buffer.sv
dv/tb_clkgen.sv
dv/tb_ingress_buffer.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f flist.f --top-module tb_ingress_buffer \
	-Mdir obj_dir > build.log 2>&1 \
	&& ./obj_dir/Vtb_ingress_buffer > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "Done: no errors" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
